//--- common/acq_defines.svh
`ifndef ACQ_DEFINES_SVH
`define ACQ_DEFINES_SVH

// ------------------------------
// Sample and stream widths
// ------------------------------

// One antenna sample from the front end
`define ACQ_SAMPLE_BITS 24

// AXI4-Stream payload width
// Samples sit zero-extended in the low bits
`define ACQ_TDATA_BITS 32

// ------------------------------
// Buffering and framing
// ------------------------------

// Log2 of the sample FIFO depth (16 entries)
`define ACQ_FIFO_DEPTH_LOG2 4

// Words in one stream packet
`define ACQ_PACKET_LEN 16

// ------------------------------
// Register bus
// ------------------------------

`define ACQ_WB_ADDR_BITS 2
`define ACQ_WB_DATA_BITS 8

// Stream address is reserved and reads back zero
`define ACQ_ADDR_STREAM 2'd0
`define ACQ_ADDR_SYSTEM 2'd3

`endif

//--- common/acq_pkg.sv
`include "acq_defines.svh"

package acq_pkg;

   // Raw antenna sample as captured
   typedef logic [`ACQ_SAMPLE_BITS-1:0] acq_sample_t;

   // Word carried on TDATA
   typedef logic [`ACQ_TDATA_BITS-1:0] acq_tdata_t;

   // ------------------------------
   // System register layouts
   // ------------------------------

   // Status layout returned on reads
   typedef struct packed {
      logic       enabled;
      // Framer is part way through a packet
      logic       stream_active;
      logic [1:0] rsvd_hi;
      // Sticky, set when a sample was dropped
      logic       oflow;
      logic [2:0] rsvd_lo;
   } acq_status_t;

   // Control layout taken from writes
   typedef struct packed {
      logic       enable_req;
      // Lower bits carry nothing on a write
      logic [6:0] unused;
   } acq_control_t;

   // Same byte, read one way and written another
   typedef union packed {
      acq_status_t  status;
      acq_control_t control;
   } acq_system_u;

endpackage

//--- fifo/acq_fifo.sv
`include "acq_defines.svh"

module acq_fifo
   import acq_pkg::*;
(
   input  logic        clock_i,
   input  logic        M_AXIS_ARESETN,
   // Sample strobe and capture enable
   input  logic        push_i,
   input  logic        enable_i,
   input  acq_sample_t data_i,
   // Stream side pops the head word
   input  logic        pop_i,
   output acq_sample_t data_o,
   output logic        not_empty_o,
   // One cycle pulse for each lost sample
   output logic        drop_o
);

   localparam int ABITS = `ACQ_FIFO_DEPTH_LOG2;
   localparam int DEPTH = 1 << ABITS;

   acq_sample_t    mem [DEPTH];
   // Extra MSB tells full from empty
   logic [ABITS:0] wr_ptr;
   logic [ABITS:0] rd_ptr;
   logic           empty;
   logic           full;
   logic           wr_req;
   logic           wr_en;
   logic           rd_en;

   // ------------------------------
   // Flags
   // ------------------------------

   assign empty = wr_ptr == rd_ptr;
   // Same slot but a lap apart
   assign full  = (wr_ptr[ABITS] != rd_ptr[ABITS])
                  && (wr_ptr[ABITS-1:0] == rd_ptr[ABITS-1:0]);

   // Capture only while enabled
   assign wr_req = push_i && enable_i;
   // Full is judged before any pop this cycle
   assign wr_en  = wr_req && !full;
   assign drop_o = wr_req && full;
   assign rd_en  = pop_i && !empty;

   // Head word is visible before it is popped
   assign data_o      = mem[rd_ptr[ABITS-1:0]];
   assign not_empty_o = !empty;

   // ------------------------------
   // Storage and pointers
   // ------------------------------

   always_ff @(posedge clock_i)
   begin
      if (wr_en)
         mem[wr_ptr[ABITS-1:0]] <= data_i;
   end

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         // Both may move in the same cycle
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

//--- design/acq_regs.sv
`include "acq_defines.svh"

module acq_regs
   import acq_pkg::*;
(
   input  logic                         clock_i,
   input  logic                         M_AXIS_ARESETN,
   // Pipelined Wishbone style slave port
   input  logic                         cyc_i,
   input  logic                         stb_i,
   input  logic                         we_i,
   input  logic [`ACQ_WB_ADDR_BITS-1:0] adr_i,
   input  logic [`ACQ_WB_DATA_BITS-1:0] dat_i,
   output logic                         ack_o,
   output logic [`ACQ_WB_DATA_BITS-1:0] dat_o,
   // Status coming in from the datapath
   input  logic                         drop_i,
   input  logic                         stream_active_i,
   // Control going out to the datapath
   output logic                         enable_o,
   output logic                         oflow_o
);

   logic        xfer;
   logic        sys_sel;
   logic        store;
   acq_system_u wr_word;
   acq_system_u rd_word;
   logic        enable_q;
   logic        oflow_q;

   // ------------------------------
   // Bus decode
   // ------------------------------

   // Every cycle with cyc and stb is a transfer
   assign xfer    = cyc_i && stb_i;
   assign sys_sel = adr_i == `ACQ_ADDR_SYSTEM;
   // Only the system register is writable
   assign store   = xfer && we_i && sys_sel;

   // Incoming byte seen through the control layout
   assign wr_word = dat_i;

   // Outgoing byte built through the status layout
   always_comb
   begin
      rd_word                      = '0;
      rd_word.status.enabled       = enable_q;
      rd_word.status.stream_active = stream_active_i;
      rd_word.status.oflow         = oflow_q;
   end

   // No wait states, ack follows one cycle later
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
         ack_o <= 1'b0;
      else
         ack_o <= xfer;
   end

   // Read data is loaded alongside ack
   always_ff @(posedge clock_i)
   begin
      if (xfer)
      begin
         // Stream and reserved addresses return zero
         if (!we_i && sys_sel)
            dat_o <= rd_word;
         else
            dat_o <= '0;
      end
   end

   // ------------------------------
   // Control and status state
   // ------------------------------

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         enable_q <= 1'b0;
         oflow_q  <= 1'b0;
      end
      else
      begin
         if (store)
            enable_q <= wr_word.control.enable_req;
         // A fresh drop wins over a clearing write
         if (drop_i)
            oflow_q <= 1'b1;
         else if (store)
            oflow_q <= 1'b0;
      end
   end

   assign enable_o = enable_q;
   assign oflow_o  = oflow_q;

endmodule

//--- design/acq_axis_framer.sv
`include "acq_defines.svh"

module acq_axis_framer
   import acq_pkg::*;
(
   input  logic        clock_i,
   input  logic        M_AXIS_ARESETN,
   // Head of the sample FIFO
   input  acq_sample_t head_i,
   input  logic        not_empty_i,
   output logic        pop_o,
   // AXI4-Stream master
   input  logic        m_axis_tready_i,
   output logic        m_axis_tvalid_o,
   output acq_tdata_t  m_axis_tdata_o,
   output logic        m_axis_tlast_o,
   // Packet in progress, for the status register
   output logic        stream_active_o
);

   localparam int CNT_BITS = $clog2(`ACQ_PACKET_LEN);
   localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(`ACQ_PACKET_LEN - 1);
   localparam int PAD_BITS = `ACQ_TDATA_BITS - `ACQ_SAMPLE_BITS;

   // Words already sent in the current packet
   logic [CNT_BITS-1:0] word_cnt;
   logic                handshake;
   logic                at_last;

   // ------------------------------
   // Stream outputs
   // ------------------------------

   // Any buffered sample is offered at once
   assign m_axis_tvalid_o = not_empty_i;
   // Upper byte padded with zeros
   assign m_axis_tdata_o  = {{PAD_BITS{1'b0}}, head_i};

   // Word moves on valid and ready together
   assign handshake = not_empty_i && m_axis_tready_i;
   assign pop_o     = handshake;

   // TLAST comes straight from the count
   assign at_last        = word_cnt == LAST_CNT;
   assign m_axis_tlast_o = not_empty_i && at_last;

   // Mid packet whenever the count is off zero
   assign stream_active_o = word_cnt != '0;

   // ------------------------------
   // Packet word counter
   // ------------------------------

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
         word_cnt <= '0;
      else if (handshake)
      begin
         // Wrap after the word carrying TLAST
         if (at_last)
            word_cnt <= '0;
         else
            word_cnt <= word_cnt + 1'b1;
      end
   end

endmodule

//--- design/acq_top.sv
`include "acq_defines.svh"

module acq_top
   import acq_pkg::*;
(
   input  logic                         clock_i,
   input  logic                         M_AXIS_ARESETN,
   // Antenna sample input
   input  logic                         strobe_i,
   input  acq_sample_t                  signal_i,
   // Register bus
   input  logic                         cyc_i,
   input  logic                         stb_i,
   input  logic                         we_i,
   input  logic [`ACQ_WB_ADDR_BITS-1:0] adr_i,
   input  logic [`ACQ_WB_DATA_BITS-1:0] dat_i,
   output logic                         ack_o,
   output logic [`ACQ_WB_DATA_BITS-1:0] dat_o,
   // Sample stream out
   input  logic                         m_axis_tready_i,
   output logic                         m_axis_tvalid_o,
   output acq_tdata_t                   m_axis_tdata_o,
   output logic                         m_axis_tlast_o,
   // Debug status
   output logic                         enabled_o,
   output logic                         oflow_o
);

   logic        acq_enable;
   logic        fifo_drop;
   logic        fifo_pop;
   logic        fifo_not_empty;
   acq_sample_t fifo_head;
   logic        stream_active;

   // Control and status registers
   acq_regs i_acq_regs (
      .clock_i         (clock_i),
      .M_AXIS_ARESETN  (M_AXIS_ARESETN),
      .cyc_i           (cyc_i),
      .stb_i           (stb_i),
      .we_i            (we_i),
      .adr_i           (adr_i),
      .dat_i           (dat_i),
      .ack_o           (ack_o),
      .dat_o           (dat_o),
      .drop_i          (fifo_drop),
      .stream_active_i (stream_active),
      .enable_o        (acq_enable),
      .oflow_o         (oflow_o)
   );

   // Strobe is gated by enable inside the FIFO
   acq_fifo i_acq_fifo (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .push_i         (strobe_i),
      .enable_i       (acq_enable),
      .data_i         (signal_i),
      .pop_i          (fifo_pop),
      .data_o         (fifo_head),
      .not_empty_o    (fifo_not_empty),
      .drop_o         (fifo_drop)
   );

   // Packetizes the FIFO head onto the stream
   acq_axis_framer i_acq_axis_framer (
      .clock_i         (clock_i),
      .M_AXIS_ARESETN  (M_AXIS_ARESETN),
      .head_i          (fifo_head),
      .not_empty_i     (fifo_not_empty),
      .pop_o           (fifo_pop),
      .m_axis_tready_i (m_axis_tready_i),
      .m_axis_tvalid_o (m_axis_tvalid_o),
      .m_axis_tdata_o  (m_axis_tdata_o),
      .m_axis_tlast_o  (m_axis_tlast_o),
      .stream_active_o (stream_active)
   );

   assign enabled_o = acq_enable;

endmodule

//--- bench/tb_acq_checks.svh
`ifndef TB_ACQ_CHECKS_SVH
`define TB_ACQ_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------

// Stream word together with its TLAST flag
task automatic check_word(input acq_tdata_t got, input logic got_last,
                          input acq_tdata_t exp, input logic exp_last);
   if (got !== exp || got_last !== exp_last)
      abort_run($sformatf("FAIL @ %0t: stream word %h last %b, expected %h last %b",
                          $time, got, got_last, exp, exp_last));
endtask

// Byte read back over the register bus
task automatic check_reg(input string what, input acq_system_u got, input acq_system_u exp);
   if (got !== exp)
      abort_run($sformatf("FAIL @ %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

// Single status or handshake line
task automatic check_flag(input string what, input logic got, input logic exp);
   if (got !== exp)
      abort_run($sformatf("FAIL @ %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// Word tallies kept by the monitor
task automatic check_count(input string what, input int got, input int exp);
   if (got != exp)
      abort_run($sformatf("FAIL @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

// ------------------------------
// Random source
// ------------------------------

// 32-bit xorshift with shifts of 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

//--- bench/tb_acq_top.sv
`include "acq_defines.svh"

module tb_acq_top
   import acq_pkg::*;
();

   localparam int FIFO_DEPTH  = 1 << `ACQ_FIFO_DEPTH_LOG2;
   localparam int DRIVE_DLY   = 10;
   // Whole run needs a few hundred cycles with ten times that as a ceiling
   localparam int CYCLE_LIMIT = 4000;

   logic                         clock_i = 1'b0;
   logic                         M_AXIS_ARESETN;
   logic                         strobe_i;
   acq_sample_t                  signal_i;
   logic                         cyc_i;
   logic                         stb_i;
   logic                         we_i;
   logic [`ACQ_WB_ADDR_BITS-1:0] adr_i;
   logic [`ACQ_WB_DATA_BITS-1:0] dat_i;
   logic                         ack_o;
   logic [`ACQ_WB_DATA_BITS-1:0] dat_o;
   logic                         m_axis_tready_i;
   logic                         m_axis_tvalid_o;
   acq_tdata_t                   m_axis_tdata_o;
   logic                         m_axis_tlast_o;
   logic                         enabled_o;
   logic                         oflow_o;

   // Reference model state
   acq_sample_t exp_q[$];
   int          pkt_pos;
   logic        model_enable;
   logic        model_oflow;
   logic        ack_due;
   logic        read_due;
   logic        sys_write;
   logic        lost;
   int          held;
   acq_system_u read_exp;
   acq_system_u wr_ctrl;
   acq_tdata_t  exp_word;
   logic        exp_last;
   int          beats = 0;
   int          err_count = 0;
   int          cycle_cnt = 0;
   // Stimulus state
   logic [31:0] rng_state;
   acq_system_u rd;
   acq_system_u exp_sys;
   int          mark;
   int          i;

   acq_top i_acq_top (.*);

   always #50 clock_i = ~clock_i;

   task automatic abort_run(input string why);
      err_count++;
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped at the first error");
   endtask

   `include "tb_acq_checks.svh"

   // ------------------------------
   // Reference model
   // ------------------------------

   // FIFO drop rule with occupancy taken before any pop this cycle
   function automatic logic capture_sample(input acq_sample_t sample, input int occupancy);
      if (occupancy >= FIFO_DEPTH)
         return 1'b1;
      exp_q.push_back(sample);
      return 1'b0;
   endfunction

   // Position inside a packet after one more transfer
   function automatic int next_pos(input int pos);
      return (pos == `ACQ_PACKET_LEN - 1) ? 0 : pos + 1;
   endfunction

   function automatic acq_sample_t next_sample();
      rng_state = xorshift32(rng_state);
      return rng_state[`ACQ_SAMPLE_BITS-1:0];
   endfunction

   // Ready three cycles out of four on average
   function automatic logic next_ready();
      rng_state = xorshift32(rng_state);
      return rng_state[31:30] != 2'b00;
   endfunction

   // Compare at the falling edge where every output has settled
   always @(negedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         exp_q.delete();
         pkt_pos      = 0;
         model_enable = 1'b0;
         model_oflow  = 1'b0;
         ack_due      = 1'b0;
         read_due     = 1'b0;
      end
      else
      begin
         check_flag("ack_o", ack_o, ack_due);
         if (read_due)
            check_reg("dat_o", dat_o, read_exp);
         check_flag("enabled_o", enabled_o, model_enable);
         check_flag("oflow_o", oflow_o, model_oflow);
         check_flag("m_axis_tvalid_o", m_axis_tvalid_o, exp_q.size() != 0);
         // Bus transfer this cycle is acked on the next
         ack_due   = cyc_i && stb_i;
         read_due  = ack_due && !we_i;
         sys_write = ack_due && we_i && adr_i == `ACQ_ADDR_SYSTEM;
         read_exp  = '0;
         if (adr_i == `ACQ_ADDR_SYSTEM)
         begin
            read_exp.status.enabled       = model_enable;
            read_exp.status.stream_active = pkt_pos != 0;
            read_exp.status.oflow         = model_oflow;
         end
         held = exp_q.size();
         if (m_axis_tvalid_o && m_axis_tready_i)
         begin
            exp_word = acq_tdata_t'(exp_q.pop_front());
            exp_last = pkt_pos == `ACQ_PACKET_LEN - 1;
            check_word(m_axis_tdata_o, m_axis_tlast_o, exp_word, exp_last);
            pkt_pos = next_pos(pkt_pos);
            beats++;
         end
         lost = 1'b0;
         if (strobe_i && model_enable)
            lost = capture_sample(signal_i, held);
         // A drop in the same cycle beats the clearing write
         if (lost)
            model_oflow = 1'b1;
         else if (sys_write)
            model_oflow = 1'b0;
         wr_ctrl = dat_i;
         if (sys_write)
            model_enable = wr_ctrl.control.enable_req;
      end
   end

   always @(posedge clock_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT)
         abort_run($sformatf("Timeout: the run did not finish in %0d cycles", CYCLE_LIMIT));
   end

   // ------------------------------
   // Drivers
   // ------------------------------

   task automatic step();
      @(posedge clock_i);
      #DRIVE_DLY;
   endtask

   task automatic send_sample(input acq_sample_t sample);
      strobe_i = 1'b1;
      signal_i = sample;
      step();
      strobe_i = 1'b0;
   endtask

   task automatic bus_write(input logic [`ACQ_WB_ADDR_BITS-1:0] addr,
                            input logic [`ACQ_WB_DATA_BITS-1:0] data);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = 1'b1;
      adr_i = addr;
      dat_i = data;
      step();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   // Ack is due exactly one cycle after the transfer
   task automatic bus_read(input logic [`ACQ_WB_ADDR_BITS-1:0] addr, output acq_system_u data);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = 1'b0;
      adr_i = addr;
      step();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      check_flag("ack one cycle after read", ack_o, 1'b1);
      data = dat_o;
   endtask

   task automatic drain_stream();
      m_axis_tready_i = 1'b1;
      while (m_axis_tvalid_o)
         step();
   endtask

   initial
   begin
      M_AXIS_ARESETN  = 1'b0;
      strobe_i        = 1'b0;
      signal_i        = '0;
      cyc_i           = 1'b0;
      stb_i           = 1'b0;
      we_i            = 1'b0;
      adr_i           = '0;
      dat_i           = '0;
      m_axis_tready_i = 1'b0;
      rng_state       = 32'hdcd6_fd06;
      repeat (2) step();
      M_AXIS_ARESETN = 1'b1;

      // Reset state and strobes ignored while disabled
      check_flag("tvalid after reset", m_axis_tvalid_o, 1'b0);
      check_flag("ack after reset", ack_o, 1'b0);
      check_flag("enabled after reset", enabled_o, 1'b0);
      check_flag("oflow after reset", oflow_o, 1'b0);
      bus_read(`ACQ_ADDR_SYSTEM, rd);
      check_reg("system after reset", rd, '0);
      m_axis_tready_i = 1'b1;
      for (i = 0; i < 4; i++)
         send_sample(next_sample());
      step();
      check_count("words while disabled", beats, 0);

      // Register access
      bus_write(`ACQ_ADDR_SYSTEM, 8'h80);
      check_flag("enabled after write", enabled_o, 1'b1);
      bus_read(`ACQ_ADDR_SYSTEM, rd);
      exp_sys = '0;
      exp_sys.status.enabled = 1'b1;
      check_reg("system status", rd, exp_sys);
      for (i = 0; i < 3; i++)
      begin
         bus_read(2'(i), rd);
         check_reg("unmapped read", rd, '0);
      end

      // ------------------------------
      // Streaming with random ready
      // ------------------------------
      mark = beats;
      for (i = 0; i < 64; i++)
      begin
         m_axis_tready_i = next_ready();
         send_sample(next_sample());
         m_axis_tready_i = next_ready();
         step();
      end
      drain_stream();
      check_count("words streamed", beats - mark, 64);

      // Packet in progress shows in bit 6
      for (i = 0; i < 3; i++)
         send_sample(next_sample());
      drain_stream();
      bus_read(`ACQ_ADDR_SYSTEM, rd);
      check_flag("stream active mid packet", rd.status.stream_active, 1'b1);
      for (i = 0; i < 13; i++)
         send_sample(next_sample());
      drain_stream();
      bus_read(`ACQ_ADDR_SYSTEM, rd);
      check_flag("stream active after packet", rd.status.stream_active, 1'b0);

      // Overflow with the sink stalled
      m_axis_tready_i = 1'b0;
      mark = beats;
      for (i = 0; i < 20; i++)
         send_sample(next_sample());
      check_flag("oflow after drops", oflow_o, 1'b1);
      drain_stream();
      check_count("kept samples", beats - mark, 16);
      bus_write(`ACQ_ADDR_SYSTEM, 8'h80);
      check_flag("oflow after clear", oflow_o, 1'b0);

      // Disable while buffered words still drain
      m_axis_tready_i = 1'b0;
      mark = beats;
      for (i = 0; i < 3; i++)
         send_sample(next_sample());
      bus_write(`ACQ_ADDR_SYSTEM, 8'h00);
      check_flag("enabled after disable", enabled_o, 1'b0);
      for (i = 0; i < 4; i++)
         send_sample(next_sample());
      drain_stream();
      check_count("words after disable", beats - mark, 3);

      step();
      if (err_count == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- list.f
+incdir+common
+incdir+bench
common/acq_pkg.sv
fifo/acq_fifo.sv
design/acq_regs.sv
design/acq_axis_framer.sv
design/acq_top.sv
bench/tb_acq_top.sv

//--- Makefile
# Verilator simulation of the capture block testbench

VERILATOR ?= verilator
TOP       ?= tb_acq_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Result is decided from the log, not the exit code of the pipe
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
